// ==== Makefile ====
# Verilator simulation of the execute unit testbench

.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module tbExUnit -f tb.f -o tbExUnit
	./obj_dir/tbExUnit 2>&1 | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== alu.sv ====
// Integer ALU: add, sub, logic ops, shifts, set-less-than, zero flag
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  execPkg::aluCtrlT         aluCtrl,   // Function select
    input  logic [execPkg::xlen-1:0] a,
    input  logic [execPkg::xlen-1:0] b,
    output logic [execPkg::xlen-1:0] result,
    output logic                     zero
);

    logic [4:0] shamt;                      // RV32 shifts use five bits
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = b[4:0];
    assign lessSigned   = ($signed(a) < $signed(b));
    assign lessUnsigned = (a < b);

    always_comb begin
        case (aluCtrl)
            execPkg::aluAdd:  result = a + b;
            execPkg::aluSub:  result = a - b;
            execPkg::aluAnd:  result = a & b;
            execPkg::aluOr:   result = a | b;
            execPkg::aluXor:  result = a ^ b;
            execPkg::aluSll:  result = a << shamt;
            execPkg::aluSrl:  result = a >> shamt;
            execPkg::aluSra:  result = $signed(a) >>> shamt;   // Sign bit fills in
            execPkg::aluSlt:  result = {{(execPkg::xlen-1){1'b0}}, lessSigned};
            execPkg::aluSltu: result = {{(execPkg::xlen-1){1'b0}}, lessUnsigned};
            default:          result = '0;  // Unused codes
        endcase
    end

    assign zero = (result == '0);           // Branch equal test

endmodule

`default_nettype wire

// ==== aluControl.sv ====
// ALU control decoder: operation class and function fields to ALU function code
`timescale 1ns/1ps
`default_nettype none

module aluControl (
    input  execPkg::aluOpT   aluOp,         // Class from control unit
    input  logic [6:0]       funct7,
    input  logic [2:0]       funct3,
    output execPkg::aluCtrlT aluCtrl
);

    logic isReg;                            // R-type may turn add into sub
    logic alt;                              // funct7 bit 5, sub and sra select

    assign isReg = (aluOp == execPkg::aluOpReg);
    assign alt   = funct7[5];

    always_comb begin
        aluCtrl = execPkg::aluAdd;          // Safe default
        case (aluOp)
            execPkg::aluOpAdd: aluCtrl = execPkg::aluAdd;
            execPkg::aluOpSub: aluCtrl = execPkg::aluSub;
            default: begin
                // R-type and I-type share the funct3 map
                case (funct3)
                    3'b000:  aluCtrl = (isReg && alt) ? execPkg::aluSub : execPkg::aluAdd;
                    3'b001:  aluCtrl = execPkg::aluSll;
                    3'b010:  aluCtrl = execPkg::aluSlt;
                    3'b011:  aluCtrl = execPkg::aluSltu;
                    3'b100:  aluCtrl = execPkg::aluXor;
                    3'b101:  aluCtrl = alt ? execPkg::aluSra : execPkg::aluSrl;
                    3'b110:  aluCtrl = execPkg::aluOr;
                    default: aluCtrl = execPkg::aluAnd;   // 3'b111
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== exMemBus.sv ====
// EX/MEM bus interface: registered execute result with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface exMemBus;

    logic                      valid;       // Result word is live this cycle
    logic [execPkg::xlen-1:0]  pc;          // Branch target or own pc
    logic [execPkg::xlen-1:0]  aluResult;
    logic [execPkg::xlen-1:0]  writeData;   // Store data
    logic [4:0]                rd;
    logic                      memRead;
    logic                      memWrite;
    logic                      memToReg;
    logic                      regWrite;

    modport source (output valid, pc, aluResult, writeData, rd,
                    memRead, memWrite, memToReg, regWrite);

    modport sink (input valid, pc, aluResult, writeData, rd,
                  memRead, memWrite, memToReg, regWrite);

endinterface

`default_nettype wire

// ==== exStage.sv ====
// Execute stage: operand select, ALU, jump and branch resolve, EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module exStage (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     stall,                 // Forces a bubble out
    idExBus.sink     idEx,
    exMemBus.source  exMem,
    output logic     clearFetch             // Flush IF/ID on taken transfer
);

    execPkg::aluCtrlT         aluCtrl;
    logic [execPkg::xlen-1:0] operandB;     // rs2 or immediate
    logic [execPkg::xlen-1:0] aluResult;
    logic [execPkg::xlen-1:0] target;       // pc-relative destination
    logic                     zero;
    logic                     taken;

    aluControl iAluControl (
        .aluOp   (idEx.aluOp),
        .funct7  (idEx.funct7),
        .funct3  (idEx.funct3),
        .aluCtrl (aluCtrl)
    );

    assign operandB = idEx.aluSrc ? idEx.immediate : idEx.readData2;

    alu iAlu (
        .aluCtrl (aluCtrl),
        .a       (idEx.readData1),
        .b       (operandB),
        .result  (aluResult),
        .zero    (zero)
    );

    assign target = idEx.pc + (idEx.immediate << 1);    // Offset is in halfwords
    assign taken  = idEx.jump | (idEx.branch & zero);   // beq only

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exMem.valid     <= 1'b0;
            exMem.pc        <= '0;
            exMem.aluResult <= '0;
            exMem.writeData <= '0;
            exMem.rd        <= '0;
            exMem.memRead   <= 1'b0;
            exMem.memWrite  <= 1'b0;
            exMem.memToReg  <= 1'b0;
            exMem.regWrite  <= 1'b0;
            clearFetch      <= 1'b0;
        end else if (stall || !idEx.valid) begin
            exMem.valid     <= 1'b0;        // Bubble, data left as is
            clearFetch      <= 1'b0;
        end else begin
            exMem.valid     <= 1'b1;
            exMem.pc        <= taken ? target : idEx.pc;
            exMem.aluResult <= aluResult;
            exMem.writeData <= idEx.readData2;   // Store data is always rs2
            exMem.rd        <= idEx.rd;
            exMem.memRead   <= idEx.memRead;
            exMem.memWrite  <= idEx.memWrite;
            exMem.memToReg  <= idEx.memToReg;
            exMem.regWrite  <= idEx.regWrite;
            clearFetch      <= taken;       // One pulse with the result
        end
    end

endmodule

`default_nettype wire

// ==== exUnit.sv ====
// Execute unit top level: ID/EX register, execute stage, flat EX/MEM ports
`timescale 1ns/1ps
`default_nettype none

module exUnit (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     stall,
    input  logic                     issueValid,     // Decode word is real
    input  logic [execPkg::xlen-1:0] issuePc,
    input  logic [execPkg::xlen-1:0] issueReadData1,
    input  logic [execPkg::xlen-1:0] issueReadData2,
    input  logic [execPkg::xlen-1:0] issueImmediate,
    input  logic [4:0]               issueRd,
    input  logic [6:0]               issueFunct7,
    input  logic [2:0]               issueFunct3,
    input  logic                     issueAluSrc,
    input  execPkg::aluOpT           issueAluOp,
    input  logic                     issueBranch,
    input  logic                     issueJump,
    input  logic                     issueMemRead,
    input  logic                     issueMemWrite,
    input  logic                     issueMemToReg,
    input  logic                     issueRegWrite,
    output logic                     memValid,
    output logic [execPkg::xlen-1:0] memPc,          // Target when taken
    output logic [execPkg::xlen-1:0] memAluResult,
    output logic [execPkg::xlen-1:0] memWriteData,
    output logic [4:0]               memRd,
    output logic                     memMemRead,
    output logic                     memMemWrite,
    output logic                     memMemToReg,
    output logic                     memRegWrite,
    output logic                     clearFetch
);

    idExBus  idEx ();                       // ID/EX register contents
    exMemBus exMem ();                      // EX/MEM register contents

    idExRegister iIdExRegister (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall          (stall),
        .issueValid     (issueValid),
        .issuePc        (issuePc),
        .issueReadData1 (issueReadData1),
        .issueReadData2 (issueReadData2),
        .issueImmediate (issueImmediate),
        .issueRd        (issueRd),
        .issueFunct7    (issueFunct7),
        .issueFunct3    (issueFunct3),
        .issueAluSrc    (issueAluSrc),
        .issueAluOp     (issueAluOp),
        .issueBranch    (issueBranch),
        .issueJump      (issueJump),
        .issueMemRead   (issueMemRead),
        .issueMemWrite  (issueMemWrite),
        .issueMemToReg  (issueMemToReg),
        .issueRegWrite  (issueRegWrite),
        .idEx           (idEx)
    );

    exStage iExStage (
        .clk        (clk),
        .reset_n    (reset_n),
        .stall      (stall),
        .idEx       (idEx),
        .exMem      (exMem),
        .clearFetch (clearFetch)
    );

    // EX/MEM word out to flat ports
    assign memValid     = exMem.valid;
    assign memPc        = exMem.pc;
    assign memAluResult = exMem.aluResult;
    assign memWriteData = exMem.writeData;
    assign memRd        = exMem.rd;
    assign memMemRead   = exMem.memRead;
    assign memMemWrite  = exMem.memWrite;
    assign memMemToReg  = exMem.memToReg;
    assign memRegWrite  = exMem.regWrite;

endmodule

`default_nettype wire

// ==== execPkg.sv ====
// Shared execute definitions: word width, ALU operation classes, ALU function codes
`default_nettype none

package execPkg;

    localparam int xlen = 32;               // RV32 data and address width

    // Operation class handed over by the main control unit
    typedef enum logic [1:0] {
        aluOpAdd = 2'b00,                   // Loads and stores, address add
        aluOpSub = 2'b01,                   // Branch compare by subtract
        aluOpReg = 2'b10,                   // R-type, funct3 plus funct7
        aluOpImm = 2'b11                    // I-type arithmetic, funct3 only
    } aluOpT;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,                     // a + b
        aluSub  = 4'd1,                     // a - b
        aluAnd  = 4'd2,                     // Bitwise and
        aluOr   = 4'd3,                     // Bitwise or
        aluXor  = 4'd4,                     // Bitwise xor
        aluSll  = 4'd5,                     // Shift left logical
        aluSrl  = 4'd6,                     // Shift right logical
        aluSra  = 4'd7,                     // Shift right arithmetic
        aluSlt  = 4'd8,                     // Set if less, signed
        aluSltu = 4'd9                      // Set if less, unsigned
    } aluCtrlT;

endpackage

`default_nettype wire

// ==== idExBus.sv ====
// ID/EX bus interface: one decoded instruction with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface idExBus;

    logic                      valid;       // Word holds a real instruction
    logic [execPkg::xlen-1:0]  pc;
    logic [execPkg::xlen-1:0]  readData1;   // rs1 value
    logic [execPkg::xlen-1:0]  readData2;   // rs2 value, also store data
    logic [execPkg::xlen-1:0]  immediate;   // Sign-extended immediate
    logic [4:0]                rd;
    logic [6:0]                funct7;
    logic [2:0]                funct3;
    logic                      aluSrc;      // High selects immediate
    execPkg::aluOpT            aluOp;
    logic                      branch;
    logic                      jump;
    logic                      memRead;
    logic                      memWrite;
    logic                      memToReg;
    logic                      regWrite;

    modport source (output valid, pc, readData1, readData2, immediate, rd, funct7, funct3,
                    aluSrc, aluOp, branch, jump, memRead, memWrite, memToReg, regWrite);

    modport sink (input valid, pc, readData1, readData2, immediate, rd, funct7, funct3,
                  aluSrc, aluOp, branch, jump, memRead, memWrite, memToReg, regWrite);

endinterface

`default_nettype wire

// ==== idExRegister.sv ====
// ID/EX pipeline register that captures issue when not stalled and holds under stall
`timescale 1ns/1ps
`default_nettype none

module idExRegister (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     stall,          // Global freeze
    input  logic                     issueValid,
    input  logic [execPkg::xlen-1:0] issuePc,
    input  logic [execPkg::xlen-1:0] issueReadData1,
    input  logic [execPkg::xlen-1:0] issueReadData2,
    input  logic [execPkg::xlen-1:0] issueImmediate,
    input  logic [4:0]               issueRd,
    input  logic [6:0]               issueFunct7,
    input  logic [2:0]               issueFunct3,
    input  logic                     issueAluSrc,
    input  execPkg::aluOpT           issueAluOp,
    input  logic                     issueBranch,
    input  logic                     issueJump,
    input  logic                     issueMemRead,
    input  logic                     issueMemWrite,
    input  logic                     issueMemToReg,
    input  logic                     issueRegWrite,
    idExBus.source                   idEx
);

    // Control half of the ID/EX word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idEx.valid    <= 1'b0;
            idEx.aluSrc   <= 1'b0;
            idEx.aluOp    <= execPkg::aluOpAdd;
            idEx.branch   <= 1'b0;
            idEx.jump     <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.memToReg <= 1'b0;
            idEx.regWrite <= 1'b0;
        end else if (!stall) begin
            idEx.valid    <= issueValid;    // Bubble when nothing issued
            idEx.aluSrc   <= issueAluSrc;
            idEx.aluOp    <= issueAluOp;
            idEx.branch   <= issueBranch;
            idEx.jump     <= issueJump;
            idEx.memRead  <= issueMemRead;
            idEx.memWrite <= issueMemWrite;
            idEx.memToReg <= issueMemToReg;
            idEx.regWrite <= issueRegWrite;
        end
    end

    // Payload half of the ID/EX word
    always_ff @(posedge clk) begin
        if (!stall) begin
            idEx.pc        <= issuePc;
            idEx.readData1 <= issueReadData1;
            idEx.readData2 <= issueReadData2;
            idEx.immediate <= issueImmediate;
            idEx.rd        <= issueRd;
            idEx.funct7    <= issueFunct7;
            idEx.funct3    <= issueFunct3;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
execPkg.sv
idExBus.sv
exMemBus.sv
aluControl.sv
alu.sv
idExRegister.sv
exStage.sv
exUnit.sv
tbExUnit.sv

// ==== tbExUnit.sv ====
// exUnit testbench with clock, reset, random issue and stall, queue model and output checker
`timescale 1ns/1ps
`default_nettype none

module tbExUnit;

    localparam int drainTimeout = 50;       // Cycles allowed for the pipe to empty
    localparam int steadyCycles = 150;      // Random issue without stall
    localparam int stallCycles  = 250;      // Random issue with random stall

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] aluResult;
        logic [31:0] writeData;
        logic [4:0]  rd;
        logic        memRead;
        logic        memWrite;
        logic        memToReg;
        logic        regWrite;
        logic        clearFetch;
    } expT;

    logic clk = 1'b0;
    logic reset_n, stall, issueValid;
    logic [31:0] issuePc, issueReadData1, issueReadData2, issueImmediate;
    logic [4:0] issueRd;
    logic [6:0] issueFunct7;
    logic [2:0] issueFunct3;
    logic issueAluSrc;
    execPkg::aluOpT issueAluOp;
    logic issueBranch, issueJump, issueMemRead, issueMemWrite, issueMemToReg, issueRegWrite;
    logic memValid, memMemRead, memMemWrite, memMemToReg, memRegWrite, clearFetch;
    logic [31:0] memPc, memAluResult, memWriteData;
    logic [4:0] memRd;

    integer seed = 85;
    expT expQ[$];                           // Results in issue order
    expT pushItem;
    expT popItem;
    logic [31:0] operandB;
    logic taken;
    logic stallSeen = 1'b0;                 // Stall sampled by the last edge
    int pushedCount = 0;
    int observedCount = 0;

    exUnit i_dut (.*);

    always #2 clk = ~clk;                   // 4 ns period

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // RV32 integer semantics for the four operation classes
    function automatic logic [31:0] modelAlu(input execPkg::aluOpT op, input logic [2:0] f3,
                                             input logic alt, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [31:0] r;
        case (op)
            execPkg::aluOpAdd: r = a + b;
            execPkg::aluOpSub: r = a - b;
            default: begin
                case (f3)
                    3'd0:    r = (alt && op == execPkg::aluOpReg) ? a - b : a + b;
                    3'd1:    r = a << b[4:0];
                    3'd2:    r = {31'd0, $signed(a) < $signed(b)};
                    3'd3:    r = {31'd0, a < b};
                    3'd4:    r = a ^ b;
                    3'd5: begin
                        if (alt)
                            r = $signed(a) >>> b[4:0];   // srai and sra
                        else
                            r = a >> b[4:0];
                    end
                    3'd6:    r = a | b;
                    default: r = a & b;
                endcase
            end
        endcase
        return r;
    endfunction

    task automatic driveInstruction(input logic allowStall);
        logic [31:0] flags;
        logic [31:0] rs1Val;
        logic [31:0] rs2Val;
        logic [31:0] fields;
        logic [31:0] pcBits;
        logic [31:0] kind;
        execPkg::aluOpT op;
        logic [6:0] ctrl;                   // aluSrc branch jump memRead memWrite memToReg regWrite
        flags  = $random(seed);
        rs1Val = $random(seed);
        rs2Val = $random(seed);
        fields = $random(seed);
        pcBits = $random(seed);
        kind   = {8'd0, flags[31:8]} % 32'd5;
        case (kind)
            32'd0: begin                                                  // R-type
                op   = execPkg::aluOpReg;
                ctrl = 7'b0000001;
            end
            32'd1: begin                                                  // I-type
                op   = execPkg::aluOpImm;
                ctrl = 7'b1000001;
            end
            32'd2: begin                                                  // Load or store
                op   = execPkg::aluOpAdd;
                ctrl = flags[6] ? 7'b1001011 : 7'b1000100;
            end
            32'd3: begin                                                  // beq
                op   = execPkg::aluOpSub;
                ctrl = 7'b0100000;
                if (flags[5])
                    rs2Val = rs1Val;        // Equal operands make it taken
            end
            default: begin                                                // Jump
                op   = execPkg::aluOpAdd;
                ctrl = 7'b1010001;
            end
        endcase
        stall          <= allowStall && (flags[1:0] == 2'b00);   // About one in four
        issueValid     <= (flags[3:2] != 2'b00);
        issuePc        <= {pcBits[31:2], 2'b00};
        issueReadData1 <= rs1Val;
        issueReadData2 <= rs2Val;
        issueImmediate <= {{20{fields[11]}}, fields[11:0]};     // 12-bit signed
        issueRd        <= fields[16:12];
        issueFunct3    <= fields[19:17];
        issueFunct7    <= {1'b0, flags[4], 5'b0};
        issueAluOp     <= op;
        {issueAluSrc, issueBranch, issueJump, issueMemRead, issueMemWrite,
         issueMemToReg, issueRegWrite} <= ctrl;
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        if (stallSeen)
            checkValue("bubble under stall", 32'd0, 32'(memValid));
        if (memValid) begin
            if (expQ.size() == 0) begin
                $display("unexpected output: memValid high with no instruction pending");
                $display("Test FAILED");
                $fatal(1, "unexpected output");
            end else begin
                popItem = expQ.pop_front();
                observedCount++;
                checkValue("memPc", popItem.pc, memPc);
                checkValue("memAluResult", popItem.aluResult, memAluResult);
                checkValue("memWriteData", popItem.writeData, memWriteData);
                checkValue("memRd", 32'(popItem.rd), 32'(memRd));
                checkValue("memMemRead", 32'(popItem.memRead), 32'(memMemRead));
                checkValue("memMemWrite", 32'(popItem.memWrite), 32'(memMemWrite));
                checkValue("memMemToReg", 32'(popItem.memToReg), 32'(memMemToReg));
                checkValue("memRegWrite", 32'(popItem.regWrite), 32'(memRegWrite));
                checkValue("clearFetch", 32'(popItem.clearFetch), 32'(clearFetch));
            end
        end else begin
            checkValue("clearFetch without result", 32'd0, 32'(clearFetch));
        end
        // Word the next rising edge captures into ID/EX
        if (reset_n && issueValid && !stall) begin
            operandB           = issueAluSrc ? issueImmediate : issueReadData2;
            pushItem.aluResult = modelAlu(issueAluOp, issueFunct3, issueFunct7[5],
                                          issueReadData1, operandB);
            taken              = issueJump || (issueBranch && pushItem.aluResult == 32'd0);
            pushItem.pc        = taken ? issuePc + (issueImmediate << 1) : issuePc;
            pushItem.writeData = issueReadData2;
            pushItem.rd        = issueRd;
            pushItem.memRead   = issueMemRead;
            pushItem.memWrite  = issueMemWrite;
            pushItem.memToReg  = issueMemToReg;
            pushItem.regWrite  = issueRegWrite;
            pushItem.clearFetch = taken;
            expQ.push_back(pushItem);
            pushedCount++;
        end
        stallSeen = stall;
    end

    initial begin
        int waited;
        reset_n        <= 1'b0;
        stall          <= 1'b0;
        issueValid     <= 1'b0;
        issuePc        <= '0;
        issueReadData1 <= '0;
        issueReadData2 <= '0;
        issueImmediate <= '0;
        issueRd        <= '0;
        issueFunct7    <= '0;
        issueFunct3    <= '0;
        issueAluSrc    <= 1'b0;
        issueAluOp     <= execPkg::aluOpAdd;
        {issueBranch, issueJump, issueMemRead, issueMemWrite} <= 4'b0;
        {issueMemToReg, issueRegWrite} <= 2'b0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) begin                    // Quiet outputs before any issue
            @(negedge clk);
            checkValue("reset memValid", 32'd0, 32'(memValid));
            checkValue("reset clearFetch", 32'd0, 32'(clearFetch));
            checkValue("reset memMemRead", 32'd0, 32'(memMemRead));
            checkValue("reset memMemWrite", 32'd0, 32'(memMemWrite));
            checkValue("reset memMemToReg", 32'd0, 32'(memMemToReg));
            checkValue("reset memRegWrite", 32'd0, 32'(memRegWrite));
            checkValue("reset memAluResult", 32'd0, memAluResult);
        end
        repeat (steadyCycles) begin
            @(posedge clk);
            driveInstruction(1'b0);
        end
        repeat (stallCycles) begin
            @(posedge clk);
            driveInstruction(1'b1);
        end
        @(posedge clk);
        issueValid <= 1'b0;
        stall      <= 1'b0;
        waited = 0;
        while (expQ.size() != 0 && waited < drainTimeout) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);          // Catch stray late outputs
        if (expQ.size() == 0 && pushedCount > 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("results went missing: %0d of %0d issued were seen",
                     observedCount, pushedCount);
            $display("Test FAILED");
            $fatal(1, "drain timeout");
        end
    end

endmodule

`default_nettype wire
